// File: source/huff_config.svh
`ifndef HUFF_CONFIG_SVH
`define HUFF_CONFIG_SVH

// block geometry
`define HUFF_BLOCK_SYMS 12
`define HUFF_TABLE_SIZE 5
`define HUFF_SYMS_PER_WORD 3

// memory bus widths
`define HUFF_ADDR_W 16
`define HUFF_RDATA_W 32
`define HUFF_WDATA_W 16

// symbols, lengths and codes share one byte width
`define HUFF_SYM_W 8

`endif

// File: source/huff_pkg.sv
`include "huff_config.svh"

package huff_pkg;

    typedef logic [`HUFF_SYM_W-1:0] sym_t;
    typedef logic [2:0] tbl_idx_t;
    typedef logic [3:0] blk_idx_t;

    // byte address and offset inside that byte, MSB first
    typedef struct packed {
        logic [4:0] byte_addr;
        logic [2:0] bit_off;
    } bit_fields_s;

    // running stream position, read either as a sum or as address/offset
    typedef union packed {
        logic [7:0]  sum;
        bit_fields_s f;
    } bit_pos_u;

    typedef struct packed {
        sym_t [`HUFF_TABLE_SIZE-1:0] syms;
        sym_t [`HUFF_TABLE_SIZE-1:0] lens;
        sym_t [`HUFF_TABLE_SIZE-1:0] codes;
    } code_tables_s;

    // stage 1 result
    typedef struct packed {
        sym_t len;
        sym_t code;
        logic last;
    } map_item_s;

    typedef struct packed {
        logic [`HUFF_ADDR_W-1:0]  addr;
        logic [`HUFF_WDATA_W-1:0] data;
    } out_word_s;

endpackage

// File: source/huff_ctrl.sv
`include "huff_config.svh"

module huff_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_valid_i,
    output logic                    start_ready_o,
    output logic [`HUFF_ADDR_W-1:0] input_addr_o,
    output logic [`HUFF_ADDR_W-1:0] symbol_addr_o,
    output logic [`HUFF_ADDR_W-1:0] length_addr_o,
    output logic [`HUFF_ADDR_W-1:0] encode_addr_o,
    output logic                    load_en_o,
    output huff_pkg::tbl_idx_t      load_idx_o,
    output logic                    issue_valid_o,
    input  logic                    issue_ready_i,
    output huff_pkg::blk_idx_t      issue_idx_o,
    output logic                    issue_last_o,
    output logic                    block_start_o,
    input  logic                    last_written_i,
    output logic                    done_o
);
    import huff_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_load,
        s_issue,
        s_drain
    } state_e;

    localparam tbl_idx_t LOAD_LAST  = tbl_idx_t'(`HUFF_TABLE_SIZE - 1);
    localparam blk_idx_t ISSUE_LAST = blk_idx_t'(`HUFF_BLOCK_SYMS - 1);

    state_e   state_q;
    state_e   state_d;
    tbl_idx_t load_cnt_q;
    blk_idx_t sym_cnt_q;
    logic     done_q;
    logic     issue_fire;
    logic [`HUFF_ADDR_W-1:0] rd_addr;

    assign issue_fire = issue_valid_o && issue_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            s_idle: begin
                if (start_valid_i) begin
                    state_d = s_load;
                end
            end
            s_load: begin
                if (load_cnt_q == LOAD_LAST) begin
                    state_d = s_issue;
                end
            end
            s_issue: begin
                if (issue_fire && issue_last_o) begin
                    state_d = s_drain;
                end
            end
            s_drain: begin
                // wait for the final word to leave the write port
                if (last_written_i) begin
                    state_d = s_idle;
                end
            end
            default: begin
                state_d = s_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= s_idle;
            load_cnt_q <= '0;
            sym_cnt_q  <= '0;
            done_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= (state_q == s_drain) && last_written_i;
            // load counter wraps to zero on the last table entry
            if (state_q == s_load) begin
                load_cnt_q <= (load_cnt_q == LOAD_LAST) ? '0 : load_cnt_q + 1'b1;
            end
            if (issue_fire) begin
                sym_cnt_q <= issue_last_o ? '0 : sym_cnt_q + 1'b1;
            end
        end
    end

    // all four memories are walked with the same index
    assign rd_addr       = {{(`HUFF_ADDR_W - 3){1'b0}}, load_cnt_q};
    assign input_addr_o  = rd_addr;
    assign symbol_addr_o = rd_addr;
    assign length_addr_o = rd_addr;
    assign encode_addr_o = rd_addr;

    assign start_ready_o = (state_q == s_idle);
    assign load_en_o     = (state_q == s_load);
    assign load_idx_o    = load_cnt_q;
    assign block_start_o = (state_q == s_load) && (load_cnt_q == '0);

    assign issue_valid_o = (state_q == s_issue);
    assign issue_idx_o   = sym_cnt_q;
    assign issue_last_o  = (sym_cnt_q == ISSUE_LAST);

    assign done_o = done_q;

endmodule

// File: source/huff_table_store.sv
`include "huff_config.svh"

module huff_table_store (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load_en_i,
    input  huff_pkg::tbl_idx_t       load_idx_i,
    input  logic [`HUFF_RDATA_W-1:0] input_rdata_i,
    input  logic [`HUFF_RDATA_W-1:0] symbol_rdata_i,
    input  logic [`HUFF_RDATA_W-1:0] length_rdata_i,
    input  logic [`HUFF_RDATA_W-1:0] encode_rdata_i,
    input  huff_pkg::blk_idx_t       issue_idx_i,
    output huff_pkg::code_tables_s   tables_o,
    output huff_pkg::sym_t           sym_o
);
    import huff_pkg::*;

    localparam int IN_WORDS = `HUFF_BLOCK_SYMS / `HUFF_SYMS_PER_WORD;

    sym_t         blk_q [`HUFF_BLOCK_SYMS];
    code_tables_s tables_q;
    logic         word_load;

    // only the first four input words carry symbols
    assign word_load = load_en_i && (int'(load_idx_i) < IN_WORDS);

    // each word holds three symbols, byte 0 first
    always_ff @(posedge clk) begin
        if (word_load) begin
            for (int j = 0; j < `HUFF_SYMS_PER_WORD; j++) begin
                blk_q[int'(load_idx_i) * `HUFF_SYMS_PER_WORD + j] <=
                    input_rdata_i[j * `HUFF_SYM_W +: `HUFF_SYM_W];
            end
        end
    end

    // tables take the low byte of each read word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tables_q <= '0;
        end else if (load_en_i) begin
            tables_q.syms[load_idx_i]  <= symbol_rdata_i[`HUFF_SYM_W-1:0];
            tables_q.lens[load_idx_i]  <= length_rdata_i[`HUFF_SYM_W-1:0];
            tables_q.codes[load_idx_i] <= encode_rdata_i[`HUFF_SYM_W-1:0];
        end
    end

    assign tables_o = tables_q;

    // symbol currently offered to stage 1
    assign sym_o = blk_q[issue_idx_i];

endmodule

// File: source/huff_symbol_map.sv
`include "huff_config.svh"

module huff_symbol_map (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  huff_pkg::sym_t         sym_i,
    input  logic                   last_i,
    input  huff_pkg::code_tables_s tables_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output huff_pkg::map_item_s    item_o
);
    import huff_pkg::*;

    tbl_idx_t  hit_idx;
    map_item_s item_d;
    map_item_s item_q;
    logic      valid_q;
    logic      accept;

    // priority match, the lowest matching entry wins
    always_comb begin
        hit_idx = '0;
        for (int i = `HUFF_TABLE_SIZE - 1; i >= 0; i--) begin
            if (tables_i.syms[i] == sym_i) begin
                hit_idx = tbl_idx_t'(i);
            end
        end
    end

    always_comb begin
        item_d.len  = tables_i.lens[hit_idx];
        item_d.code = tables_i.codes[hit_idx];
        item_d.last = last_i;
    end

    // accept when empty or draining this cycle
    assign in_ready_o = !valid_q || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            item_q <= item_d;
        end
    end

    assign out_valid_o = valid_q;
    assign item_o      = item_q;

endmodule

// File: source/huff_bit_packer.sv
`include "huff_config.svh"

module huff_bit_packer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear_i,
    input  logic                in_valid_i,
    output logic                in_ready_o,
    input  huff_pkg::map_item_s item_i,
    output logic                wr_valid_o,
    input  logic                wr_ready_i,
    output huff_pkg::out_word_s wr_o,
    output logic                last_written_o
);
    import huff_pkg::*;

    bit_pos_u  pos_q;
    out_word_s word_d;
    out_word_s word_q;
    logic      valid_q;
    logic      last_q;
    logic      accept;
    logic [7:0] shamt;
    logic [`HUFF_WDATA_W-1:0] code_ext;

    assign in_ready_o = !valid_q || wr_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    // left-align the code inside the byte pair at the current offset
    assign shamt    = 8'd16 - item_i.len - {5'b0, pos_q.f.bit_off};
    assign code_ext = {{(`HUFF_WDATA_W - `HUFF_SYM_W){1'b0}}, item_i.code};

    always_comb begin
        word_d.addr = {{(`HUFF_ADDR_W - 5){1'b0}}, pos_q.f.byte_addr};
        word_d.data = code_ext << shamt;
    end

    // running bit position, restarted at each block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos_q.sum <= '0;
        end else if (clear_i) begin
            pos_q.sum <= '0;
        end else if (accept) begin
            pos_q.sum <= pos_q.sum + item_i.len;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
            last_q  <= in_valid_i && item_i.last;
        end
    end

    // word stays put while the write port stalls
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= word_d;
        end
    end

    assign wr_valid_o     = valid_q;
    assign wr_o           = word_q;
    assign last_written_o = valid_q && wr_ready_i && last_q;

endmodule

// File: source/huff_enc_top.sv
`include "huff_config.svh"

module huff_enc_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start_valid_i,
    output logic                     start_ready_o,
    output logic [`HUFF_ADDR_W-1:0]  input_addr_o,
    input  logic [`HUFF_RDATA_W-1:0] input_rdata_i,
    output logic [`HUFF_ADDR_W-1:0]  symbol_addr_o,
    input  logic [`HUFF_RDATA_W-1:0] symbol_rdata_i,
    output logic [`HUFF_ADDR_W-1:0]  length_addr_o,
    input  logic [`HUFF_RDATA_W-1:0] length_rdata_i,
    output logic [`HUFF_ADDR_W-1:0]  encode_addr_o,
    input  logic [`HUFF_RDATA_W-1:0] encode_rdata_i,
    output logic                     wr_valid_o,
    input  logic                     wr_ready_i,
    output logic [`HUFF_ADDR_W-1:0]  wr_addr_o,
    output logic [`HUFF_WDATA_W-1:0] wr_data_o,
    output logic                     done_o
);
    import huff_pkg::*;

    logic         load_en;
    tbl_idx_t     load_idx;
    logic         issue_valid;
    logic         issue_ready;
    blk_idx_t     issue_idx;
    logic         issue_last;
    logic         block_start;
    logic         last_written;
    code_tables_s tables;
    sym_t         issue_sym;
    logic         map_valid;
    logic         map_ready;
    map_item_s    map_item;
    out_word_s    wr_word;

    huff_ctrl u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_valid_i  (start_valid_i),
        .start_ready_o  (start_ready_o),
        .input_addr_o   (input_addr_o),
        .symbol_addr_o  (symbol_addr_o),
        .length_addr_o  (length_addr_o),
        .encode_addr_o  (encode_addr_o),
        .load_en_o      (load_en),
        .load_idx_o     (load_idx),
        .issue_valid_o  (issue_valid),
        .issue_ready_i  (issue_ready),
        .issue_idx_o    (issue_idx),
        .issue_last_o   (issue_last),
        .block_start_o  (block_start),
        .last_written_i (last_written),
        .done_o         (done_o)
    );

    huff_table_store u_store (
        .clk            (clk),
        .rst_n          (rst_n),
        .load_en_i      (load_en),
        .load_idx_i     (load_idx),
        .input_rdata_i  (input_rdata_i),
        .symbol_rdata_i (symbol_rdata_i),
        .length_rdata_i (length_rdata_i),
        .encode_rdata_i (encode_rdata_i),
        .issue_idx_i    (issue_idx),
        .tables_o       (tables),
        .sym_o          (issue_sym)
    );

    // stage 1
    huff_symbol_map u_map (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (issue_valid),
        .in_ready_o  (issue_ready),
        .sym_i       (issue_sym),
        .last_i      (issue_last),
        .tables_i    (tables),
        .out_valid_o (map_valid),
        .out_ready_i (map_ready),
        .item_o      (map_item)
    );

    // stage 2 drives the write port
    huff_bit_packer u_packer (
        .clk            (clk),
        .rst_n          (rst_n),
        .clear_i        (block_start),
        .in_valid_i     (map_valid),
        .in_ready_o     (map_ready),
        .item_i         (map_item),
        .wr_valid_o     (wr_valid_o),
        .wr_ready_i     (wr_ready_i),
        .wr_o           (wr_word),
        .last_written_o (last_written)
    );

    assign wr_addr_o = wr_word.addr;
    assign wr_data_o = wr_word.data;

endmodule

// File: bench/huff_tb_clock.sv
module huff_tb_clock (
    output logic clk_o
);

    // period of 4 time units
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #2 clk_o = ~clk_o;
    end

endmodule

// File: bench/huff_tb.sv
`include "huff_config.svh"

module huff_tb;

    localparam int BLK = `HUFF_BLOCK_SYMS;
    localparam int TBL = `HUFF_TABLE_SIZE;
    localparam int N_RAND = 5;
    // 13 blocks at about 60 cycles each under the worst stall ratio, with wide margin
    localparam int CYCLE_LIMIT = 4000;

    logic                     clk;
    logic                     rst_n;
    logic                     start_valid;
    logic                     start_ready;
    logic [`HUFF_ADDR_W-1:0]  input_addr;
    logic [`HUFF_ADDR_W-1:0]  symbol_addr;
    logic [`HUFF_ADDR_W-1:0]  length_addr;
    logic [`HUFF_ADDR_W-1:0]  encode_addr;
    logic [`HUFF_RDATA_W-1:0] input_mem [8];
    logic [`HUFF_RDATA_W-1:0] symbol_mem [8];
    logic [`HUFF_RDATA_W-1:0] length_mem [8];
    logic [`HUFF_RDATA_W-1:0] encode_mem [8];
    logic                     wr_valid;
    logic                     wr_ready;
    logic [`HUFF_ADDR_W-1:0]  wr_addr;
    logic [`HUFF_WDATA_W-1:0] wr_data;
    logic                     done;

    // block under test and its expected results
    logic [7:0]  tab_sym [TBL];
    logic [7:0]  tab_len [TBL];
    logic [7:0]  tab_code [TBL];
    logic [7:0]  blk_in [BLK];
    logic [15:0] exp_addr [BLK];
    logic [15:0] exp_data [BLK];
    logic [7:0]  exp_bytes [16];
    logic [7:0]  out_mem [16];

    // saved random blocks replayed with and without stalls
    logic [7:0]  r_sym [N_RAND][TBL];
    logic [7:0]  r_len [N_RAND][TBL];
    logic [7:0]  r_code [N_RAND][TBL];
    logic [7:0]  r_in [N_RAND][BLK];

    logic [31:0] lfsr;
    int          checks;
    int          errors;
    int          cycles;

    huff_tb_clock u_clock (
        .clk_o (clk)
    );

    huff_enc_top DUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_valid_i  (start_valid),
        .start_ready_o  (start_ready),
        .input_addr_o   (input_addr),
        .input_rdata_i  (input_mem[input_addr[2:0]]),
        .symbol_addr_o  (symbol_addr),
        .symbol_rdata_i (symbol_mem[symbol_addr[2:0]]),
        .length_addr_o  (length_addr),
        .length_rdata_i (length_mem[length_addr[2:0]]),
        .encode_addr_o  (encode_addr),
        .encode_rdata_i (encode_mem[encode_addr[2:0]]),
        .wr_valid_o     (wr_valid),
        .wr_ready_i     (wr_ready),
        .wr_addr_o      (wr_addr),
        .wr_data_o      (wr_data),
        .done_o         (done)
    );

    // galois lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic check(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("[FAIL] %0t: %s", $time, msg);
        end
    endtask

    // upper bytes carry junk so only the low byte may be used
    task automatic load_memories();
        for (int i = 0; i < 8; i++) begin
            symbol_mem[i] = {8'(i), 16'hc35a, (i < TBL) ? tab_sym[i] : 8'h00};
            length_mem[i] = {8'(i), 16'h5ac3, (i < TBL) ? tab_len[i] : 8'h00};
            encode_mem[i] = {8'(i), 16'h9669, (i < TBL) ? tab_code[i] : 8'h00};
            input_mem[i]  = {8'(i) ^ 8'h96, 24'h0};
        end
        for (int w = 0; w < BLK / 3; w++) begin
            input_mem[w][23:0] = {blk_in[3 * w + 2], blk_in[3 * w + 1], blk_in[3 * w]};
        end
    endtask

    // first matching entry wins and its code goes msb first to the running position
    task automatic build_expected();
        int pos;
        int hit;
        int len;
        logic [7:0] code;
        pos = 0;
        for (int b = 0; b < 16; b++) begin
            exp_bytes[b] = '0;
        end
        for (int s = 0; s < BLK; s++) begin
            hit = -1;
            for (int i = 0; i < TBL; i++) begin
                if (hit < 0 && tab_sym[i] == blk_in[s]) begin
                    hit = i;
                end
            end
            len = int'(tab_len[hit]);
            code = tab_code[hit];
            exp_addr[s] = 16'(pos / 8);
            exp_data[s] = '0;
            for (int j = 0; j < len; j++) begin
                exp_data[s][15 - pos % 8 - j] = code[len - 1 - j];
                if (code[len - 1 - j]) begin
                    exp_bytes[(pos + j) / 8][7 - (pos + j) % 8] = 1'b1;
                end
            end
            pos += len;
        end
    endtask

    // entered on a falling edge with the DUT idle and returns on the done cycle
    task automatic run_block(input bit random_ready, input bit hold_start);
        int n_wr;
        bit pend_last;
        bit stalled;
        bit seen_done;
        logic [15:0] held_addr;
        logic [15:0] held_data;
        load_memories();
        build_expected();
        for (int b = 0; b < 16; b++) begin
            out_mem[b] = '0;
        end
        n_wr = 0;
        pend_last = 1'b0;
        stalled = 1'b0;
        seen_done = 1'b0;
        check(start_ready === 1'b1, "start_ready_o low at block start");
        start_valid = 1'b1;
        while (!seen_done) begin
            @(negedge clk);
            if (!hold_start) begin
                start_valid = 1'b0;
            end
            seen_done = (done === 1'b1);
            check(seen_done == pend_last,
                  $sformatf("done_o is %b, expected %b", done, pend_last));
            check(start_ready === seen_done, "start_ready_o high inside a block");
            check(input_addr < TBL && symbol_addr === input_addr &&
                  length_addr === input_addr && encode_addr === input_addr,
                  "read addresses disagree or leave the tables");
            if (stalled) begin
                check(wr_valid === 1'b1 && wr_addr === held_addr && wr_data === held_data,
                      "write word changed while stalled");
            end
            wr_ready = random_ready ? 1'(take_bits(1)) : 1'b1;
            pend_last = 1'b0;
            stalled = wr_valid && !wr_ready;
            held_addr = wr_addr;
            held_data = wr_data;
            if (wr_valid === 1'b1 && wr_ready) begin
                check(n_wr < BLK, "write after the last symbol of the block");
                if (n_wr < BLK) begin
                    check(wr_addr === exp_addr[n_wr] && wr_data === exp_data[n_wr],
                          $sformatf("write %0d got %h/%h, expected %h/%h", n_wr,
                                    wr_addr, wr_data, exp_addr[n_wr], exp_data[n_wr]));
                    out_mem[wr_addr[3:0]] |= wr_data[15:8];
                    out_mem[wr_addr[3:0] + 4'd1] |= wr_data[7:0];
                end
                n_wr++;
                pend_last = (n_wr == BLK);
            end
        end
        check(n_wr == BLK, $sformatf("%0d writes in the block, expected %0d", n_wr, BLK));
        for (int b = 0; b < 16; b++) begin
            check(out_mem[b] === exp_bytes[b],
                  $sformatf("stream byte %0d is %h, expected %h", b, out_mem[b], exp_bytes[b]));
        end
    endtask

    task automatic gen_random_blocks();
        logic [7:0] cand;
        logic [2:0] idx;
        bit dup;
        for (int b = 0; b < N_RAND; b++) begin
            for (int i = 0; i < TBL; i++) begin
                do begin
                    cand = 8'(take_bits(8));
                    dup = 1'b0;
                    for (int j = 0; j < i; j++) begin
                        dup |= (r_sym[b][j] == cand);
                    end
                end while (dup);
                r_sym[b][i] = cand;
                r_len[b][i] = 8'd1 + 8'(take_bits(3));
                r_code[b][i] = 8'(take_bits(8)) & ((8'd1 << r_len[b][i]) - 8'd1);
            end
            for (int s = 0; s < BLK; s++) begin
                do begin
                    idx = 3'(take_bits(3));
                end while (idx >= TBL);
                r_in[b][s] = r_sym[b][idx];
            end
        end
    endtask

    task automatic use_random_block(input int b);
        tab_sym = r_sym[b];
        tab_len = r_len[b];
        tab_code = r_code[b];
        blk_in = r_in[b];
    endtask

    task automatic test_reset_state();
        check(start_ready === 1'b1 && wr_valid === 1'b0 && done === 1'b0,
              "wrong handshake levels after reset");
        check(input_addr === '0 && symbol_addr === '0 && length_addr === '0 &&
              encode_addr === '0, "read address not zero after reset");
        repeat (8) begin
            @(negedge clk);
            check(wr_valid === 1'b0 && done === 1'b0, "activity without a start");
        end
    endtask

    task automatic test_fixed_block();
        string txt;
        txt = "ABACADAEBBCE";
        tab_sym = '{8'h41, 8'h42, 8'h43, 8'h44, 8'h45};
        tab_len = '{8'd1, 8'd2, 8'd3, 8'd4, 8'd4};
        tab_code = '{8'h00, 8'h02, 8'h06, 8'h0e, 8'h0f};
        for (int s = 0; s < BLK; s++) begin
            blk_in[s] = txt[s];
        end
        run_block(1'b0, 1'b0);
    endtask

    task automatic test_random_blocks(input bit random_ready);
        for (int b = 0; b < N_RAND; b++) begin
            use_random_block(b);
            run_block(random_ready, 1'b0);
        end
    endtask

    // symbol 20 sits at entries 1 and 3 so entry 1 must win
    task automatic test_duplicate_and_back_to_back();
        tab_sym = '{8'h10, 8'h20, 8'h30, 8'h20, 8'h40};
        tab_len = '{8'd2, 8'd3, 8'd2, 8'd5, 8'd2};
        tab_code = '{8'h01, 8'h05, 8'h02, 8'h1b, 8'h03};
        blk_in = '{8'h20, 8'h10, 8'h20, 8'h30, 8'h20, 8'h40,
                   8'h20, 8'h20, 8'h10, 8'h30, 8'h40, 8'h20};
        run_block(1'b1, 1'b1);
        use_random_block(0);
        run_block(1'b0, 1'b0);
    endtask

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("cycle limit of %0d reached before the tests finished", CYCLE_LIMIT);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        lfsr = 32'hbf8e_5951;
        checks = 0;
        errors = 0;
        rst_n = 1'b0;
        start_valid = 1'b0;
        wr_ready = 1'b1;
        for (int i = 0; i < 8; i++) begin
            input_mem[i] = '0;
            symbol_mem[i] = '0;
            length_mem[i] = '0;
            encode_mem[i] = '0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_fixed_block();
        gen_random_blocks();
        test_random_blocks(1'b0);
        test_random_blocks(1'b1);
        test_duplicate_and_back_to_back();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: huff_enc.f
+incdir+source
source/huff_pkg.sv
source/huff_ctrl.sv
source/huff_table_store.sv
source/huff_symbol_map.sv
source/huff_bit_packer.sv
source/huff_enc_top.sv
bench/huff_tb_clock.sv
bench/huff_tb.sv

// File: Makefile
SIM    := verilator
FLAGS  := --binary --timing -Wno-fatal
TOP    := huff_tb
FLIST  := huff_enc.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
SRCS   := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

# the run fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
